/* logic/forth_pkg.sv */
//############################################################
// shared types for the data stack unit: cell, command and
// controller state, imported by the RTL and the testbench
//############################################################
package forth_pkg;

    typedef logic [31:0] data_t;          // one stack cell

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_PUSH = 4'd1,                   // push literal
        OP_DROP = 4'd2,
        OP_DUP  = 4'd3,
        OP_SWAP = 4'd4,
        OP_OVER = 4'd5,
        OP_ADD  = 4'd6,                   // second + tos
        OP_SUB  = 4'd7,                   // second - tos
        OP_AND  = 4'd8,
        OP_XOR  = 4'd9
    } op_e;

    typedef struct packed {
        op_e   op;                        // opcode, upper 4 bits
        data_t lit;                       // literal for push
    } stack_cmd_t;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_FETCH  = 2'd1,
        ST_FINISH = 2'd2
    } ctrl_state_e;

    // tos load source select
    localparam logic [1:0] TOS_LIT  = 2'd0;    // literal
    localparam logic [1:0] TOS_RAM  = 2'd1;    // cell read from ram
    localparam logic [1:0] TOS_ALU  = 2'd2;    // second op tos
    localparam logic [1:0] TOS_ZERO = 2'd3;    // stack went empty

endpackage : forth_pkg

/* logic/stack_ram.sv */
//############################################################
// single-port cell store below tos, sync read and write,
// address picked from the depth counter pointers
//############################################################
`timescale 1ns/1ps

module stack_ram #(
    parameter int DEPTH = 16,
    parameter int SSZ   = $clog2(DEPTH)
) (
    input  logic             clk,
    input  logic             we,
    input  logic             sel_rd,      // 1: rd_ptr, 0: wr_ptr
    input  logic [SSZ-1:0]   wr_ptr,
    input  logic [SSZ-1:0]   rd_ptr,
    input  forth_pkg::data_t wdata,
    output forth_pkg::data_t q
);
    import forth_pkg::*;

    localparam int CELLS = DEPTH - 1;      // tos lives outside

    data_t          mem [CELLS];           // cell array
    logic [SSZ-1:0] addr;

    assign addr = sel_rd ? rd_ptr : wr_ptr; // one port, two pointers

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        q <= mem[addr];                     // valid next cycle
    end

    // the controller only writes slots that exist
    a_addr_range: assert property (
        @(posedge clk) we |-> (int'(addr) < CELLS)
    ) else $error("stack_ram write outside cell array");

endmodule : stack_ram

/* logic/stack_depth.sv */
//############################################################
// item counter for the stack, tos included; derives the ram
// pointers and the limit flags the controller tests
//############################################################
`timescale 1ns/1ps

module stack_depth #(
    parameter int DEPTH = 16,
    parameter int SSZ   = $clog2(DEPTH)
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           inc,           // item added
    input  logic           dec,           // item removed
    output logic [SSZ:0]   depth,
    output logic [SSZ-1:0] wr_ptr,        // free slot above ram cells
    output logic [SSZ-1:0] rd_ptr,        // top cell held in ram
    output logic           is_full,
    output logic           has_one,
    output logic           has_two
);

    localparam logic [SSZ:0] MAX_ITEMS = (SSZ+1)'(DEPTH);

    logic [SSZ:0] depth_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            depth_q <= '0;
        end else if (inc) begin
            depth_q <= depth_q + 1'b1;
        end else if (dec) begin
            depth_q <= depth_q - 1'b1;
        end
    end

    // ram holds depth-1 cells in slots 0 .. depth-2
    assign wr_ptr  = depth_q[SSZ-1:0] - SSZ'(1);
    assign rd_ptr  = depth_q[SSZ-1:0] - SSZ'(2);

    assign depth   = depth_q;
    assign is_full = (depth_q == MAX_ITEMS);
    assign has_one = |depth_q;
    assign has_two = (depth_q >= (SSZ+1)'(2));   // two operands present

    a_no_inc_full: assert property (
        @(posedge clk) disable iff (rst) !(inc && is_full)
    ) else $error("depth increment while full");

    a_no_dec_empty: assert property (
        @(posedge clk) disable iff (rst) !(dec && !has_one)
    ) else $error("depth decrement while empty");

endmodule : stack_depth

/* logic/tos_alu.sv */
//############################################################
// top of stack register and the alu that folds the second
// cell into it; loads from literal, ram read or alu result
//############################################################
`timescale 1ns/1ps

module tos_alu (
    input  logic             clk,
    input  logic             rst,
    input  logic             load,        // update tos this cycle
    input  logic [1:0]       src,         // TOS_LIT / RAM / ALU / ZERO
    input  forth_pkg::op_e   op,
    input  forth_pkg::data_t lit,
    input  forth_pkg::data_t q,           // second cell from ram
    output forth_pkg::data_t tos
);
    import forth_pkg::*;

    data_t alu_res;
    data_t tos_nxt;

    // second cell is the left operand
    always_comb begin
        case (op)
            OP_ADD:  alu_res = q + tos;   // wraps at 32 bits
            OP_SUB:  alu_res = q - tos;
            OP_AND:  alu_res = q & tos;
            OP_XOR:  alu_res = q ^ tos;
            default: alu_res = q;
        endcase
    end

    always_comb begin
        case (src)
            TOS_LIT: tos_nxt = lit;
            TOS_RAM: tos_nxt = q;
            TOS_ALU: tos_nxt = alu_res;
            default: tos_nxt = '0;       // last item dropped
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tos <= '0;
        end else if (load) begin
            tos <= tos_nxt;
        end
    end

endmodule : tos_alu

/* logic/stack_ctrl.sv */
//############################################################
// command decode and sequencing for the data stack; checks
// limits, drives ram, depth counter and tos strobes
//############################################################
`timescale 1ns/1ps

module stack_ctrl #(
    parameter int DEPTH = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,   // strobe, taken while idle
    input  forth_pkg::stack_cmd_t cmd,
    input  logic                  is_full,
    input  logic                  has_one,
    input  logic                  has_two,
    output logic                  busy,
    output logic                  err,         // refused command pulse
    output logic                  inc,
    output logic                  dec,
    output logic                  ram_we,
    output logic                  ram_sel_rd,
    output logic                  tos_load,
    output logic [1:0]            tos_src,
    output forth_pkg::op_e        op,
    output forth_pkg::data_t      lit
);
    import forth_pkg::*;

    ctrl_state_e state;
    op_e         op_q;                    // held for the finish cycle
    logic        accept, refuse, go;
    logic        need_one, need_two, grows, two_cyc;

    if (DEPTH < 2) begin : g_depth_chk
        $error("stack depth must hold two operands");
    end

    assign need_one = cmd.op inside {OP_DROP, OP_DUP};
    assign need_two = cmd.op inside {OP_SWAP, OP_OVER, OP_ADD, OP_SUB, OP_AND, OP_XOR};
    assign grows    = cmd.op inside {OP_PUSH, OP_DUP, OP_OVER};
    assign two_cyc  = need_two || (cmd.op == OP_DROP);   // needs second cell

    assign accept = cmd_valid && (state == ST_IDLE);
    assign refuse = (need_one && !has_one) || (need_two && !has_two)
                 || (grows && is_full);
    assign go     = accept && !refuse;

    always_comb begin
        inc        = 1'b0;
        dec        = 1'b0;
        ram_we     = 1'b0;
        ram_sel_rd = 1'b0;
        tos_load   = 1'b0;
        tos_src    = TOS_LIT;
        if (state == ST_IDLE) begin
            if (go) begin
                case (cmd.op)
                    OP_PUSH: begin
                        ram_we   = has_one;   // spill old tos, none when empty
                        tos_load = 1'b1;
                        inc      = 1'b1;
                    end
                    OP_DUP: begin
                        ram_we = 1'b1;        // copy tos to wr_ptr
                        inc    = 1'b1;
                    end
                    OP_NOP: ;
                    default: ram_sel_rd = 1'b1;   // read second cell
                endcase
            end
        end else begin
            // q holds the second cell now
            case (op_q)
                OP_DROP: begin
                    tos_load = 1'b1;
                    tos_src  = has_two ? TOS_RAM : TOS_ZERO;
                    dec      = 1'b1;
                end
                OP_SWAP: begin
                    ram_we     = 1'b1;        // old tos into rd_ptr
                    ram_sel_rd = 1'b1;
                    tos_load   = 1'b1;
                    tos_src    = TOS_RAM;
                end
                OP_OVER: begin
                    ram_we   = 1'b1;          // tos to wr_ptr
                    tos_load = 1'b1;
                    tos_src  = TOS_RAM;
                    inc      = 1'b1;
                end
                default: begin
                    tos_load = 1'b1;          // alu ops
                    tos_src  = TOS_ALU;
                    dec      = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            busy  <= 1'b0;
            err   <= 1'b0;
        end else begin
            err <= accept && refuse;          // one-cycle pulse
            if (state == ST_IDLE) begin
                if (go && two_cyc) begin
                    state <= ST_FINISH;
                    busy  <= 1'b1;
                end
            end else begin
                state <= ST_IDLE;             // finish lasts one cycle
                busy  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            op_q <= cmd.op;
        end
    end

    assign op  = op_q;
    assign lit = cmd.lit;                     // push loads on accept edge

    a_inc_dec_excl: assert property (
        @(posedge clk) disable iff (rst) !(inc && dec)
    ) else $error("depth inc and dec together");

    // operands tested at accept still present when q is used
    a_finish_operands: assert property (
        @(posedge clk) disable iff (rst)
        (state == ST_FINISH) |-> ((op_q == OP_DROP) ? has_one : has_two)
    ) else $error("operand count changed while busy");

endmodule : stack_ctrl

/* logic/forth_stack_top.sv */
//############################################################
// data stack unit top: controller, depth counter, cell ram
// and tos register; DEPTH sets the item limit
//############################################################
`timescale 1ns/1ps

module forth_stack_top #(
    parameter int DEPTH = 16,
    parameter int SSZ   = $clog2(DEPTH)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    input  forth_pkg::stack_cmd_t cmd,
    output logic                  busy,
    output logic                  err,
    output forth_pkg::data_t      tos,
    output logic [SSZ:0]          depth
);
    import forth_pkg::*;

    logic           inc, dec;
    logic           is_full, has_one, has_two;
    logic [SSZ-1:0] wr_ptr, rd_ptr;
    logic           ram_we, ram_sel_rd;
    logic           tos_load;
    logic [1:0]     tos_src;
    op_e            op;
    data_t          lit, q;

    stack_ctrl #(.DEPTH(DEPTH)) u_ctrl (
        .clk(clk), .rst(rst),
        .cmd_valid(cmd_valid), .cmd(cmd),
        .is_full(is_full), .has_one(has_one), .has_two(has_two),
        .busy(busy), .err(err),
        .inc(inc), .dec(dec),
        .ram_we(ram_we), .ram_sel_rd(ram_sel_rd),
        .tos_load(tos_load), .tos_src(tos_src),
        .op(op), .lit(lit)
    );

    stack_depth #(.DEPTH(DEPTH)) u_depth (
        .clk(clk), .rst(rst),
        .inc(inc), .dec(dec),
        .depth(depth), .wr_ptr(wr_ptr), .rd_ptr(rd_ptr),
        .is_full(is_full), .has_one(has_one), .has_two(has_two)
    );

    stack_ram #(.DEPTH(DEPTH)) u_ram (
        .clk(clk),
        .we(ram_we), .sel_rd(ram_sel_rd),
        .wr_ptr(wr_ptr), .rd_ptr(rd_ptr),
        .wdata(tos),                       // only tos is ever spilled
        .q(q)
    );

    tos_alu u_tos (
        .clk(clk), .rst(rst),
        .load(tos_load), .src(tos_src),
        .op(op), .lit(lit), .q(q),
        .tos(tos)
    );

endmodule : forth_stack_top

/* include/stack_vectors.svh */
//############################################################
// command table for the stack testbench, one row per command
// with the tos, depth and err expected once it has completed
//############################################################
`ifndef STACK_VECTORS_SVH
`define STACK_VECTORS_SVH

typedef struct packed {
    stack_cmd_t cmd;                      // command to issue
    data_t      tos;                      // tos once done
    logic [7:0] depth;                    // item count once done
    logic       err;                      // refusal expected
} vec_row_t;

vec_row_t vectors [$];

task automatic add_row(input op_e op, input data_t lit, input data_t exp_tos,
                       input int exp_depth, input logic exp_err);
    vec_row_t r;
    r.cmd.op  = op;
    r.cmd.lit = lit;
    r.tos     = exp_tos;
    r.depth   = 8'(exp_depth);
    r.err     = exp_err;
    vectors.push_back(r);
endtask

// columns: opcode, literal, expected tos, expected depth, expected err
task automatic load_vectors();
    add_row(OP_DROP, 32'h0,         32'h0,         0, 1'b1);  // empty underflow
    add_row(OP_DUP,  32'h0,         32'h0,         0, 1'b1);
    add_row(OP_ADD,  32'h0,         32'h0,         0, 1'b1);
    add_row(OP_NOP,  32'h0,         32'h0,         0, 1'b0);
    add_row(OP_PUSH, 32'h11,        32'h11,        1, 1'b0);
    add_row(OP_ADD,  32'h0,         32'h11,        1, 1'b1);  // one operand only
    add_row(OP_OVER, 32'h0,         32'h11,        1, 1'b1);
    add_row(OP_PUSH, 32'h22,        32'h22,        2, 1'b0);
    add_row(OP_PUSH, 32'h33,        32'h33,        3, 1'b0);
    add_row(OP_PUSH, 32'h44,        32'h44,        4, 1'b0);  // now full
    add_row(OP_PUSH, 32'h55,        32'h44,        4, 1'b1);  // overflow
    add_row(OP_DUP,  32'h0,         32'h44,        4, 1'b1);
    add_row(OP_OVER, 32'h0,         32'h44,        4, 1'b1);
    add_row(OP_DROP, 32'h0,         32'h33,        3, 1'b0);  // reverse order
    add_row(OP_DROP, 32'h0,         32'h22,        2, 1'b0);
    add_row(OP_DROP, 32'h0,         32'h11,        1, 1'b0);
    add_row(OP_DROP, 32'h0,         32'h0,         0, 1'b0);  // empty shows zero
    add_row(OP_DROP, 32'h0,         32'h0,         0, 1'b1);
    add_row(OP_PUSH, 32'h5,         32'h5,         1, 1'b0);
    add_row(OP_PUSH, 32'h9,         32'h9,         2, 1'b0);
    add_row(OP_SWAP, 32'h0,         32'h5,         2, 1'b0);  // 9 5
    add_row(OP_DROP, 32'h0,         32'h9,         1, 1'b0);
    add_row(OP_DUP,  32'h0,         32'h9,         2, 1'b0);  // 9 9
    add_row(OP_PUSH, 32'h3,         32'h3,         3, 1'b0);  // 9 9 3
    add_row(OP_OVER, 32'h0,         32'h9,         4, 1'b0);  // 9 9 3 9
    add_row(OP_ADD,  32'h0,         32'hC,         3, 1'b0);  // 9 9 c
    add_row(OP_SUB,  32'h0,         32'hFFFF_FFFD, 2, 1'b0);  // 9 - c
    add_row(OP_XOR,  32'h0,         32'hFFFF_FFF4, 1, 1'b0);
    add_row(OP_PUSH, 32'h0F0F_00FF, 32'h0F0F_00FF, 2, 1'b0);
    add_row(OP_AND,  32'h0,         32'h0F0F_00F4, 1, 1'b0);
    add_row(OP_PUSH, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 2, 1'b0);
    add_row(OP_ADD,  32'h0,         32'h0F0F_00F3, 1, 1'b0);  // carry dropped
    add_row(OP_PUSH, 32'h8000_0000, 32'h8000_0000, 2, 1'b0);
    add_row(OP_PUSH, 32'h8000_0000, 32'h8000_0000, 3, 1'b0);
    add_row(OP_ADD,  32'h0,         32'h0,         2, 1'b0);  // wraps to zero
    add_row(OP_SUB,  32'h0,         32'h0F0F_00F3, 1, 1'b0);
    add_row(OP_PUSH, 32'h10,        32'h10,        2, 1'b0);
    add_row(OP_PUSH, 32'h3,         32'h3,         3, 1'b0);
    add_row(OP_SUB,  32'h0,         32'hD,         2, 1'b0);  // 0x10 - 3
    add_row(OP_XOR,  32'h0,         32'h0F0F_00FE, 1, 1'b0);
    add_row(OP_DROP, 32'h0,         32'h0,         0, 1'b0);
endtask

`endif

/* test/forth_stack_tb.sv */
//############################################################
// testbench for the data stack unit: runs the command table
// on a DEPTH 4 stack, checks tos, depth, err and busy length
//############################################################
`timescale 1ns/1ps

module forth_stack_tb;
    import forth_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int TB_DEPTH     = 4;             // overflow reached quickly
    localparam int SSZ          = $clog2(TB_DEPTH);

    logic         clk;
    logic         rst;
    logic         cmd_valid;
    stack_cmd_t   cmd;
    logic         busy;
    logic         err;
    data_t        tos;
    logic [SSZ:0] depth;
    logic         rows_loaded;                   // table built, watchdog may start

    `include "stack_vectors.svh"

    forth_stack_top #(.DEPTH(TB_DEPTH)) uut (
        .clk(clk),
        .rst(rst),
        .cmd_valid(cmd_valid),
        .cmd(cmd),
        .busy(busy),
        .err(err),
        .tos(tos),
        .depth(depth)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("FAIL at %0t: %s is %0h, expected %0h", $time, what, got, expected);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // busy cycles per command: one for the read-then-finish ops
    function automatic int expected_busy(input op_e op, input logic refused);
        if (refused) begin
            return 0;                            // refusal never leaves idle
        end
        case (op)
            OP_NOP, OP_PUSH, OP_DUP: return 0;   // single cycle
            default: return 1;
        endcase
    endfunction

    task automatic run_row(input int idx, input vec_row_t row);
        logic err_seen;
        int   busy_cycles;
        @(posedge clk);
        #2;
        cmd_valid = 1'b1;
        cmd       = row.cmd;
        @(posedge clk);                          // dut takes the strobe
        #2;
        cmd_valid   = 1'b0;
        err_seen    = err;                       // pulse only in this cycle
        busy_cycles = 0;
        while (busy) begin                       // watchdog bounds this
            busy_cycles++;
            @(posedge clk);
            #2;
        end
        check_value($sformatf("row %0d err", idx), 64'(err_seen), 64'(row.err));
        check_value($sformatf("row %0d busy cycles", idx), 64'(busy_cycles),
                    64'(expected_busy(row.cmd.op, row.err)));
        check_value($sformatf("row %0d tos", idx), 64'(tos), 64'(row.tos));
        check_value($sformatf("row %0d depth", idx), 64'(depth), 64'(row.depth));
    endtask

    initial begin : stimulus
        rst         = 1'b1;
        cmd_valid   = 1'b0;
        cmd.op      = OP_NOP;
        cmd.lit     = '0;
        rows_loaded = 1'b0;
        load_vectors();
        rows_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        // state straight out of reset
        check_value("tos after reset", 64'(tos), 64'd0);
        check_value("depth after reset", 64'(depth), 64'd0);
        check_value("err after reset", 64'(err), 64'd0);
        check_value("busy after reset", 64'(busy), 64'd0);

        foreach (vectors[i]) begin
            run_row(i, vectors[i]);
        end

        $display("All tests passed!");
        $finish;
    end

    initial begin : watchdog
        wait (rows_loaded);
        #((RESET_CYCLES + vectors.size() * 10) * CLK_PERIOD);  // ten clocks per row
        $display("timeout: the command table did not finish in the allowed time");
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

endmodule : forth_stack_tb

/* filelist.f */
+incdir+include
logic/forth_pkg.sv
logic/stack_ram.sv
logic/stack_depth.sv
logic/tos_alu.sv
logic/stack_ctrl.sv
logic/forth_stack_top.sv
test/forth_stack_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the stack testbench with Verilator, run it and judge the log.
cd "$(dirname "$0")" || exit 1

TOP=forth_stack_tb
BUILD_LOG=build.log
LOG=sim.log

echo "building $TOP"
if ! verilator --binary --timing --assert --top-module "$TOP" \
        -f filelist.f -o "$TOP" > "$BUILD_LOG" 2>&1; then
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

echo "running $TOP"
./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if ! grep -q "All tests passed!" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
